//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_top
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_MSG  = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- design/command_decoder.sv
// header classification for the command engine
// looks at the word at the FIFO head and says whether it opens a write,
// a read or a packet that is passed through; purely combinational
`timescale 1ns/1ps

module command_decoder (
   input  ualink_pkg::word_t     head_word,
   input  logic                  head_last,
   output ualink_pkg::cmd_kind_t cmd_kind,
   output ualink_pkg::mem_addr_t cmd_addr
);
   import ualink_pkg::*;

   opcode_t opcode;
   logic    is_write;
   logic    is_read;

   // opcode in the top 16 bits and the base address below it
   assign opcode   = head_word[OPC_MSB:OPC_LSB];
   assign cmd_addr = head_word[ADDR_MSB:ADDR_LSB];

   assign is_write = opcode == OPC_WRITE;
   assign is_read  = opcode == OPC_READ;

   always_comb begin
      cmd_kind = CMD_PASS;  // anything unknown goes out unchanged

      if (is_write) begin
         // a write header with last has no payload
         // so the packet is just forwarded
         if (!head_last) begin
            cmd_kind = CMD_WRITE;
         end
      end else if (is_read) begin
         cmd_kind = CMD_READ;   // tlast on the header only skips the drain
      end
   end

endmodule

//--- design/command_engine.sv
// execute FSM of the command port
// takes packets from the ingress FIFO one word per cycle, writes payload
// words to memory, issues the eight reads of a read command and hands
// passthrough words to the response stage
`timescale 1ns/1ps

module command_engine (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  ualink_pkg::word_t     head_word,
   input  logic                  head_last,
   input  logic                  head_valid,
   input  ualink_pkg::cmd_kind_t cmd_kind,
   input  ualink_pkg::mem_addr_t cmd_addr,
   input  logic                  resp_space,
   output logic                  pop,
   output logic                  mem_we,
   output ualink_pkg::mem_addr_t mem_addr,
   output ualink_pkg::word_t     mem_wdata,
   output logic                  fwd_valid,
   output ualink_pkg::word_t     fwd_word,
   output logic                  fwd_last,
   output logic                  rd_issue,
   output logic                  rd_last
);
   import ualink_pkg::*;

   engine_state_t state, state_next;
   burst_cnt_t    burst_cnt, burst_cnt_next;
   mem_addr_t     addr_q, addr_next;
   logic          hdr_last_q, hdr_last_next;  // read header ended the packet
   logic          tail_q;                     // eighth read went out last cycle

   assign mem_addr  = addr_q;
   assign mem_wdata = head_word;
   assign fwd_word  = head_word;
   assign fwd_last  = head_last;

   always_comb begin
      state_next     = state;
      burst_cnt_next = burst_cnt;
      addr_next      = addr_q;
      hdr_last_next  = hdr_last_q;
      pop            = 1'b0;
      mem_we         = 1'b0;
      fwd_valid      = 1'b0;
      rd_issue       = 1'b0;
      rd_last        = 1'b0;

      case (state)
         ST_IDLE: begin
            if (head_valid) begin
               case (cmd_kind)
                  CMD_WRITE: begin
                     pop        = 1'b1;
                     addr_next  = cmd_addr;
                     state_next = ST_WRITE;
                  end
                  CMD_READ: begin
                     pop            = 1'b1;
                     addr_next      = cmd_addr;
                     burst_cnt_next = '0;
                     hdr_last_next  = head_last;
                     state_next     = ST_READ;
                  end
                  default: begin
                     // the last read word lands in the response buffer this
                     // cycle, so hold the forward port one cycle
                     if (resp_space && !tail_q) begin
                        pop       = 1'b1;
                        fwd_valid = 1'b1;
                        if (!head_last) state_next = ST_PASS;
                     end
                  end
               endcase
            end
         end

         ST_PASS: begin
            if (head_valid && resp_space) begin
               pop       = 1'b1;
               fwd_valid = 1'b1;
               if (head_last) state_next = ST_IDLE;
            end
         end

         ST_WRITE: begin
            if (head_valid) begin
               pop       = 1'b1;
               mem_we    = 1'b1;
               addr_next = addr_q + 1'b1;  // 8-bit wrap
               if (head_last) state_next = ST_IDLE;
            end
         end

         ST_READ: begin
            if (resp_space) begin
               rd_issue       = 1'b1;
               addr_next      = addr_q + 1'b1;
               burst_cnt_next = burst_cnt + 1'b1;
               if (burst_cnt == burst_cnt_t'(BURST_WORDS - 1)) begin
                  rd_last    = 1'b1;
                  state_next = hdr_last_q ? ST_IDLE : ST_DRAIN;
               end
            end
         end

         ST_DRAIN: begin
            // trailing words of a read packet are dropped
            if (head_valid) begin
               pop = 1'b1;
               if (head_last) state_next = ST_IDLE;
            end
         end

         default: state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state      <= ST_IDLE;
         burst_cnt  <= '0;
         addr_q     <= '0;
         hdr_last_q <= 1'b0;
         tail_q     <= 1'b0;
      end else begin
         state      <= state_next;
         burst_cnt  <= burst_cnt_next;
         addr_q     <= addr_next;
         hdr_last_q <= hdr_last_next;
         tail_q     <= rd_issue && rd_last;
      end
   end

endmodule

//--- design/ingress_fifo.sv
// input buffer for the command port
// fall-through FIFO of data words plus their last flags; the head is
// visible without a read strobe and pop removes it
`timescale 1ns/1ps

module ingress_fifo (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  ualink_pkg::word_t s_axis_tdata,
   input  logic              s_axis_tvalid,
   input  logic              s_axis_tlast,
   input  logic              pop,
   output logic              s_axis_tready,
   output ualink_pkg::word_t head_word,
   output logic              head_last,
   output logic              head_valid
);
   import ualink_pkg::*;

   word_t                         fifo_data [1 << IN_FIFO_DEPTH_BITS];
   logic                          fifo_last [1 << IN_FIFO_DEPTH_BITS];
   logic [IN_FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [IN_FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [IN_FIFO_DEPTH_BITS:0]   fill;   // one extra bit so full is representable
   logic                          push;

   // ready drops early so words already in flight still fit
   assign s_axis_tready = fill <
      (IN_FIFO_DEPTH_BITS + 1)'((1 << IN_FIFO_DEPTH_BITS) - IN_FIFO_SLACK);
   assign push = s_axis_tvalid && s_axis_tready;

   assign head_word  = fifo_data[rd_ptr];
   assign head_last  = fifo_last[rd_ptr];
   assign head_valid = fill != '0;

   always_ff @(posedge axi_aclk) begin
      if (push) begin
         fifo_data[wr_ptr] <= s_axis_tdata;
         fifo_last[wr_ptr] <= s_axis_tlast;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

endmodule

//--- design/payload_ram.sv
// payload memory for write and read packets
// single port, write on the clock edge, read data registered one cycle
// after the address
`timescale 1ns/1ps

module payload_ram (
   input  logic                  axi_aclk,
   input  logic                  mem_we,
   input  ualink_pkg::mem_addr_t mem_addr,
   input  ualink_pkg::word_t     mem_wdata,
   output ualink_pkg::word_t     mem_rdata
);
   import ualink_pkg::*;

   word_t mem [MEM_DEPTH];

   always_ff @(posedge axi_aclk) begin
      if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
      end
      mem_rdata <= mem[mem_addr];  // old data on a same-address write
   end

endmodule

//--- design/response_stream.sv
// output stage of the command port
// lines up memory read data with its issue strobe, merges it with
// forwarded words and buffers both in a small FIFO that drives m_axis
`timescale 1ns/1ps

module response_stream (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  logic              fwd_valid,
   input  ualink_pkg::word_t fwd_word,
   input  logic              fwd_last,
   input  logic              rd_issue,
   input  logic              rd_last,
   input  ualink_pkg::word_t mem_rdata,
   input  logic              m_axis_tready,
   output ualink_pkg::word_t m_axis_tdata,
   output logic              m_axis_tvalid,
   output logic              m_axis_tlast,
   output logic              resp_space
);
   import ualink_pkg::*;

   word_t                          slot_data [RESP_DEPTH];
   logic                           slot_last [RESP_DEPTH];
   logic [$clog2(RESP_DEPTH)-1:0]  wr_ptr;
   logic [$clog2(RESP_DEPTH)-1:0]  rd_ptr;
   logic [$clog2(RESP_DEPTH):0]    count;
   logic                           rd_pend_q;   // read data valid on mem_rdata
   logic                           rd_last_q;
   logic                           push;
   word_t                          push_word;
   logic                           push_last;
   logic                           out_fire;

   // reads and forwards never arrive in the same cycle
   assign push      = rd_pend_q || fwd_valid;
   assign push_word = rd_pend_q ? mem_rdata : fwd_word;
   assign push_last = rd_pend_q ? rd_last_q : fwd_last;

   assign m_axis_tdata  = slot_data[rd_ptr];
   assign m_axis_tlast  = slot_last[rd_ptr];
   assign m_axis_tvalid = count != '0;
   assign out_fire      = m_axis_tvalid && m_axis_tready;

   // two free slots cover the one read still in flight
   assign resp_space = count <= ($clog2(RESP_DEPTH) + 1)'(RESP_DEPTH - 2);

   always_ff @(posedge axi_aclk) begin
      rd_last_q <= rd_last;
      if (push) begin
         slot_data[wr_ptr] <= push_word;
         slot_last[wr_ptr] <= push_last;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         rd_pend_q <= 1'b0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
      end else begin
         rd_pend_q <= rd_issue;
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (out_fire) rd_ptr <= rd_ptr + 1'b1;
         case ({push, out_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- design/ualink_pkg.sv
// shared types and constants for the ualink command port
// every design module imports this package; port lists use scoped names
package ualink_pkg;

   // widths that carry a meaning
   typedef logic [63:0] word_t;      // stream and memory word
   typedef logic [7:0]  mem_addr_t;  // payload memory address
   typedef logic [15:0] opcode_t;    // header opcode field
   typedef logic [3:0]  burst_cnt_t; // word position inside a burst

   // decoder verdict on a header word
   typedef enum logic [1:0] {
      CMD_PASS,
      CMD_WRITE,
      CMD_READ
   } cmd_kind_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PASS,
      ST_WRITE,
      ST_READ,
      ST_DRAIN
   } engine_state_t;

   localparam opcode_t OPC_WRITE = 16'h0245;
   localparam opcode_t OPC_READ  = 16'h0145;

   // header field positions
   localparam int OPC_MSB  = 63;
   localparam int OPC_LSB  = 48;
   localparam int ADDR_MSB = 47;
   localparam int ADDR_LSB = 40;

   localparam int BURST_WORDS        = 8;   // read response length, max write
   localparam int IN_FIFO_DEPTH_BITS = 4;
   localparam int IN_FIFO_SLACK      = 2;   // free entries left when ready drops
   localparam int RESP_DEPTH         = 4;
   localparam int MEM_DEPTH          = 256;

endpackage

//--- design/ualink_turbo_top.sv
// top level of the ualink command port
// one 64-bit AXI-Stream in, one out; writes land in the payload memory,
// reads return eight words, everything else passes through
`timescale 1ns/1ps

module ualink_turbo_top (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  ualink_pkg::word_t s_axis_tdata,
   input  logic              s_axis_tvalid,
   output logic              s_axis_tready,
   input  logic              s_axis_tlast,
   output ualink_pkg::word_t m_axis_tdata,
   output logic              m_axis_tvalid,
   input  logic              m_axis_tready,
   output logic              m_axis_tlast
);
   import ualink_pkg::*;

   // FIFO head
   word_t     head_word;
   logic      head_last;
   logic      head_valid;
   logic      pop;

   cmd_kind_t cmd_kind;
   mem_addr_t cmd_addr;

   // memory port
   logic      mem_we;
   mem_addr_t mem_addr;
   word_t     mem_wdata;
   word_t     mem_rdata;

   // engine to response stage
   logic      fwd_valid;
   word_t     fwd_word;
   logic      fwd_last;
   logic      rd_issue;
   logic      rd_last;
   logic      resp_space;

   ingress_fifo u_ingress_fifo (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tlast  (s_axis_tlast),
      .pop           (pop),
      .s_axis_tready (s_axis_tready),
      .head_word     (head_word),
      .head_last     (head_last),
      .head_valid    (head_valid)
   );

   command_decoder u_command_decoder (
      .head_word (head_word),
      .head_last (head_last),
      .cmd_kind  (cmd_kind),
      .cmd_addr  (cmd_addr)
   );

   command_engine u_command_engine (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .head_word  (head_word),
      .head_last  (head_last),
      .head_valid (head_valid),
      .cmd_kind   (cmd_kind),
      .cmd_addr   (cmd_addr),
      .resp_space (resp_space),
      .pop        (pop),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .fwd_valid  (fwd_valid),
      .fwd_word   (fwd_word),
      .fwd_last   (fwd_last),
      .rd_issue   (rd_issue),
      .rd_last    (rd_last)
   );

   payload_ram u_payload_ram (
      .axi_aclk  (axi_aclk),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   response_stream u_response_stream (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .fwd_valid     (fwd_valid),
      .fwd_word      (fwd_word),
      .fwd_last      (fwd_last),
      .rd_issue      (rd_issue),
      .rd_last       (rd_last),
      .mem_rdata     (mem_rdata),
      .m_axis_tready (m_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tlast  (m_axis_tlast),
      .resp_space    (resp_space)
   );

endmodule

//--- list.f
design/ualink_pkg.sv
design/ingress_fifo.sv
design/command_decoder.sv
design/payload_ram.sv
design/command_engine.sv
design/response_stream.sv
design/ualink_turbo_top.sv
verif/tb_top.sv

//--- verif/tb_top.sv
// testbench for the ualink command port
// directed packets first, then random writes, reads and passthrough
// packets with input gaps and output back-pressure; every output word is
// compared against a model memory and an expected-word queue
`timescale 1ns/1ps

module tb_top;
   import ualink_pkg::*;

   localparam int CLK_PERIOD_NS = 40;
   localparam int RESET_CYCLES  = 10;
   localparam int N_DIRECTED    = 7;
   localparam int N_RANDOM      = 200;
   localparam int N_PACKETS     = N_DIRECTED + N_RANDOM;
   localparam int SEED          = 32'h7e86;

   logic  axi_aclk = 1'b0;
   logic  axi_resetn;
   word_t s_axis_tdata;
   logic  s_axis_tvalid;
   logic  s_axis_tready;
   logic  s_axis_tlast;
   word_t m_axis_tdata;
   logic  m_axis_tvalid;
   logic  m_axis_tready = 1'b1;
   logic  m_axis_tlast;

   integer seed       = SEED;
   integer ready_seed = ~SEED;  // own stream for back-pressure
   bit     gaps_on    = 1'b0;
   bit     bp_on      = 1'b0;
   int     hold_cnt   = 0;

   // model state
   word_t model_mem [MEM_DEPTH];
   bit    written   [MEM_DEPTH];
   word_t exp_word  [$];
   logic  exp_last  [$];
   word_t pkt       [$];        // packet being built

   ualink_turbo_top dut (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tlast  (m_axis_tlast)
   );

   always #(CLK_PERIOD_NS / 2) axi_aclk = ~axi_aclk;

   task automatic abort_run;
      $display("Some tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         abort_run();
      end
   endtask

   task automatic check_last(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         abort_run();
      end
   endtask

   // handshake and status bits
   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         abort_run();
      end
   endtask

   function automatic word_t rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   // true when all eight words from base hold written data
   function automatic bit covered(input mem_addr_t base);
      int i;
      for (i = 0; i < BURST_WORDS; i++) begin
         if (!written[mem_addr_t'(base + i)]) return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge axi_aclk);
         #1;
      end
   endtask

   // called 1 ns after an edge; holds the word until it is taken
   task automatic send_word(input word_t data, input logic last);
      logic taken;
      taken         = 1'b0;
      s_axis_tdata  = data;
      s_axis_tlast  = last;
      s_axis_tvalid = 1'b1;
      while (!taken) begin
         taken = s_axis_tready;  // stable until the next edge
         @(posedge axi_aclk);
         #1;
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic send_pkt;
      int n;
      int i;
      n = pkt.size();
      for (i = 0; i < n; i++) begin
         send_word(pkt[i], i == n - 1);
         if (gaps_on && ({$random(seed)} % 4) == 0) begin
            idle_cycles(1 + {$random(seed)} % 3);
         end
      end
      pkt.delete();
   endtask

   task automatic gen_pass(input int len);
      word_t   w;
      opcode_t opc;
      int      i;
      opc = opcode_t'($random(seed));
      while (opc == OPC_WRITE || opc == OPC_READ) opc = opcode_t'($random(seed));
      for (i = 0; i < len; i++) begin
         w = rand_word();
         if (i == 0) w[OPC_MSB:OPC_LSB] = opc;
         pkt.push_back(w);
         exp_word.push_back(w);
         exp_last.push_back(i == len - 1);
      end
      send_pkt();
   endtask

   // len 0 gives a lone header with last, which passes through
   task automatic gen_write(input mem_addr_t base, input int len);
      word_t     w;
      mem_addr_t a;
      int        i;
      w = rand_word();
      w[OPC_MSB:OPC_LSB]   = OPC_WRITE;
      w[ADDR_MSB:ADDR_LSB] = base;
      pkt.push_back(w);
      if (len == 0) begin
         exp_word.push_back(w);
         exp_last.push_back(1'b1);
      end
      for (i = 0; i < len; i++) begin
         w = rand_word();
         a = mem_addr_t'(base + i);  // 8-bit wrap
         model_mem[a] = w;
         written[a]   = 1'b1;
         pkt.push_back(w);
      end
      send_pkt();
   endtask

   task automatic gen_read(input mem_addr_t base, input int extra);
      word_t w;
      int    i;
      w = rand_word();
      w[OPC_MSB:OPC_LSB]   = OPC_READ;
      w[ADDR_MSB:ADDR_LSB] = base;
      pkt.push_back(w);
      for (i = 0; i < extra; i++) pkt.push_back(rand_word());  // dropped by DUT
      for (i = 0; i < BURST_WORDS; i++) begin
         exp_word.push_back(model_mem[mem_addr_t'(base + i)]);
         exp_last.push_back(i == BURST_WORDS - 1);
      end
      send_pkt();
   endtask

   // random back-pressure held for a few cycles at a time
   always @(posedge axi_aclk) begin
      #1;
      if (!bp_on) begin
         m_axis_tready = 1'b1;
      end else if (hold_cnt == 0) begin
         m_axis_tready = ({$random(ready_seed)} % 10) < 6;
         hold_cnt      = {$random(ready_seed)} % 4;
      end else begin
         hold_cnt--;
      end
   end

   // output monitor; a word seen at the falling edge transfers at the next rise
   always @(negedge axi_aclk) begin
      if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
         if (exp_word.size() == 0) begin
            $display("unexpected output word 0x%h with nothing left to expect", m_axis_tdata);
            abort_run();
         end else begin
            check_word("m_axis_tdata", m_axis_tdata, exp_word.pop_front());
            check_last("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
         end
      end
   end

   initial begin
      #(N_PACKETS * 40 * CLK_PERIOD_NS + RESET_CYCLES * CLK_PERIOD_NS);
      $display("timeout: the DUT did not deliver all expected words in time");
      abort_run();
   end

   initial begin
      int        i;
      int        kind;
      mem_addr_t base;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      repeat (RESET_CYCLES) @(posedge axi_aclk);
      #1;
      axi_resetn = 1'b1;
      idle_cycles(1);
      check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
      check_flag("s_axis_tready", s_axis_tready, 1'b1);

      gen_pass(5);
      gen_write(8'h10, BURST_WORDS);
      gen_read(8'h10, 0);
      gen_write(8'h12, 3);      // partial overwrite
      gen_read(8'h10, 0);
      gen_read(8'h10, 4);       // trailing words must vanish
      gen_write(8'h40, 0);

      gaps_on = 1'b1;
      bp_on   = 1'b1;
      for (i = 0; i < N_RANDOM; i++) begin
         kind = {$random(seed)} % 8;
         base = mem_addr_t'(8'hf4 + {$random(seed)} % 16);  // crosses the wrap
         case (kind)
            0, 1:    gen_pass(1 + {$random(seed)} % 6);
            2, 3, 4: gen_write(base, 1 + {$random(seed)} % BURST_WORDS);
            5, 6: begin
               if (covered(base)) gen_read(base, {$random(seed)} % 3);
               else gen_write(base, BURST_WORDS);
            end
            default: gen_write(base, 0);
         endcase
      end

      while (exp_word.size() != 0) @(posedge axi_aclk);
      bp_on = 1'b0;
      idle_cycles(20);          // quiet period to catch stray words
      check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
      $display("All tests passed");
      $finish;
   end

endmodule
